//--- common/db_pkg.sv
package db_pkg;

    // ==================================================
    // Widths and depth
    // ==================================================
    localparam int KEY_W   = 8;
    localparam int VALUE_W = 32;
    localparam int DEPTH   = 2 ** KEY_W;

    typedef logic [KEY_W-1:0]   db_key_t;
    typedef logic [VALUE_W-1:0] db_value_t;

    // ==================================================
    // Opcodes
    // ==================================================
    // Codes 5 to 7 are illegal and complete with error
    typedef enum logic [2:0] {
        OP_GET       = 3'd0,
        OP_SET       = 3'd1,
        OP_UNSET     = 3'd2,
        OP_REPLACE   = 3'd3,
        OP_CLEAR_ALL = 3'd4
    } db_opcode_e;

    // ==================================================
    // Port and store words
    // ==================================================
    // Command issued by a controller
    typedef struct packed {
        db_opcode_e opcode;
        db_key_t    key;
        db_value_t  value;
    } db_cmd_t;

    // Result returned with ack
    typedef struct packed {
        logic      error;
        logic      valid;
        db_value_t value;
    } db_resp_t;

    // One word of the store
    typedef struct packed {
        logic      valid;
        db_value_t value;
    } db_entry_t;

endpackage

//--- db_engine/db_peripheral.sv
module db_peripheral import db_pkg::*; (
    input  logic      clk,
    input  logic      srst,

    // Control port
    input  logic      req,
    input  db_cmd_t   cmd,
    output logic      rdy,
    output logic      ack,
    output db_resp_t  resp,

    // Store port
    output logic      rd_en,
    output logic      wr_en,
    output db_key_t   key,
    output db_entry_t wr_entry,
    input  db_entry_t rd_entry,
    output logic      wipe,
    input  logic      wipe_busy
);

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        READ,
        UPDATE,
        ACK,
        WIPE
    } state_e;

    state_e    state;
    db_cmd_t   cmd_q;
    db_resp_t  resp_q;
    logic      clear_pending;
    logic      writes;
    db_value_t prev_value;

    // ==================================================
    // FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (srst) begin
            state         <= INIT;
            wipe          <= 1'b0;
            clear_pending <= 1'b0;
        end else begin
            wipe <= 1'b0;
            case (state)
                INIT: begin
                    wipe  <= 1'b1;
                    state <= WIPE;
                end
                IDLE: begin
                    if (req) begin
                        if (cmd.opcode == OP_CLEAR_ALL) begin
                            wipe          <= 1'b1;
                            clear_pending <= 1'b1;
                            state         <= WIPE;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                READ: begin
                    state <= UPDATE;
                end
                UPDATE: begin
                    state <= ACK;
                end
                ACK: begin
                    state <= IDLE;
                end
                WIPE: begin
                    // Busy lags the pulse by a cycle
                    if (!wipe && !wipe_busy) begin
                        clear_pending <= 1'b0;
                        state         <= clear_pending ? ACK : IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign rdy   = (state == IDLE);
    assign ack   = (state == ACK);
    assign rd_en = (state == READ);

    // ==================================================
    // Command and response
    // ==================================================
    assign prev_value = rd_entry.valid ? rd_entry.value : '0;

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cmd_q  <= cmd;
            resp_q <= '0;
        end else if (state == UPDATE) begin
            case (cmd_q.opcode)
                OP_GET, OP_SET, OP_UNSET, OP_REPLACE: begin
                    resp_q.error <= 1'b0;
                    resp_q.valid <= rd_entry.valid;
                    resp_q.value <= prev_value;
                end
                default: begin
                    resp_q.error <= 1'b1;
                    resp_q.valid <= 1'b0;
                    resp_q.value <= '0;
                end
            endcase
        end
    end

    // Unset writes an invalid, zero entry
    always_comb begin
        writes   = 1'b0;
        wr_entry = '0;
        case (cmd_q.opcode)
            OP_SET, OP_REPLACE: begin
                writes         = 1'b1;
                wr_entry.valid = 1'b1;
                wr_entry.value = cmd_q.value;
            end
            OP_UNSET: begin
                writes = 1'b1;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    assign wr_en = (state == UPDATE) && writes;
    assign key   = cmd_q.key;
    assign resp  = resp_q;

endmodule

//--- db_engine/db_store_array.sv
module db_store_array import db_pkg::*; (
    input  logic      clk,
    input  logic      srst,

    input  logic      rd_en,
    input  logic      wr_en,
    input  db_key_t   key,
    input  db_entry_t wr_entry,
    output db_entry_t rd_entry,

    input  logic      wipe,
    output logic      wipe_busy
);

    db_entry_t mem [DEPTH];
    db_key_t   wipe_addr;

    // ==================================================
    // Wipe sequencer
    // ==================================================
    // Clears one entry per cycle until the last address
    always_ff @(posedge clk) begin
        if (srst) begin
            wipe_busy <= 1'b0;
            wipe_addr <= '0;
        end else if (wipe_busy) begin
            wipe_addr <= wipe_addr + 1'b1;
            if (wipe_addr == db_key_t'(DEPTH - 1)) begin
                wipe_busy <= 1'b0;
            end
        end else if (wipe) begin
            wipe_busy <= 1'b1;
            wipe_addr <= '0;
        end
    end

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (wipe_busy) begin
            mem[wipe_addr] <= '0;
        end else if (wr_en) begin
            mem[key] <= wr_entry;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= mem[key];
        end
    end

endmodule

//--- db_mux/db_ctrl_prio_mux.sv
module db_ctrl_prio_mux import db_pkg::*; (
    input  logic     clk,
    input  logic     srst,

    // Port 0, high priority
    input  logic     hi_req,
    input  db_cmd_t  hi_cmd,
    output logic     hi_rdy,
    output logic     hi_ack,
    output db_resp_t hi_resp,

    // Port 1, low priority
    input  logic     lo_req,
    input  db_cmd_t  lo_cmd,
    output logic     lo_rdy,
    output logic     lo_ack,
    output db_resp_t lo_resp,

    // Peripheral side
    output logic     per_req,
    output db_cmd_t  per_cmd,
    input  logic     per_rdy,
    input  logic     per_ack,
    input  db_resp_t per_resp
);

    logic busy;
    logic owner_lo;
    logic accept;

    // ==================================================
    // Request selection
    // ==================================================
    // Port 0 wins whenever it requests
    assign per_req = !busy && (hi_req || lo_req);
    assign per_cmd = hi_req ? hi_cmd : lo_cmd;

    assign hi_rdy = !busy && per_rdy;
    assign lo_rdy = !busy && per_rdy && !hi_req;

    assign accept = per_req && per_rdy;

    // ==================================================
    // Ownership
    // ==================================================
    always_ff @(posedge clk) begin
        if (srst) begin
            busy     <= 1'b0;
            owner_lo <= 1'b0;
        end else if (accept) begin
            busy     <= 1'b1;
            owner_lo <= !hi_req;
        end else if (per_ack) begin
            busy <= 1'b0;
        end
    end

    // Ack and response go back to the owner only
    assign hi_ack = per_ack && busy && !owner_lo;
    assign lo_ack = per_ack && busy && owner_lo;

    assign hi_resp = owner_lo ? '0 : per_resp;
    assign lo_resp = owner_lo ? per_resp : '0;

endmodule

//--- logic/db_subsystem.sv
module db_subsystem import db_pkg::*; (
    input  logic     clk,
    input  logic     srst,

    input  logic     hi_req,
    input  db_cmd_t  hi_cmd,
    output logic     hi_rdy,
    output logic     hi_ack,
    output db_resp_t hi_resp,

    input  logic     lo_req,
    input  db_cmd_t  lo_cmd,
    output logic     lo_rdy,
    output logic     lo_ack,
    output db_resp_t lo_resp
);

    logic      per_req;
    db_cmd_t   per_cmd;
    logic      per_rdy;
    logic      per_ack;
    db_resp_t  per_resp;

    logic      rd_en;
    logic      wr_en;
    db_key_t   key;
    db_entry_t wr_entry;
    db_entry_t rd_entry;
    logic      wipe;
    logic      wipe_busy;

    db_ctrl_prio_mux db_ctrl_prio_mux_inst (
        .clk      (clk),
        .srst     (srst),
        .hi_req   (hi_req),
        .hi_cmd   (hi_cmd),
        .hi_rdy   (hi_rdy),
        .hi_ack   (hi_ack),
        .hi_resp  (hi_resp),
        .lo_req   (lo_req),
        .lo_cmd   (lo_cmd),
        .lo_rdy   (lo_rdy),
        .lo_ack   (lo_ack),
        .lo_resp  (lo_resp),
        .per_req  (per_req),
        .per_cmd  (per_cmd),
        .per_rdy  (per_rdy),
        .per_ack  (per_ack),
        .per_resp (per_resp)
    );

    db_peripheral db_peripheral_inst (
        .clk       (clk),
        .srst      (srst),
        .req       (per_req),
        .cmd       (per_cmd),
        .rdy       (per_rdy),
        .ack       (per_ack),
        .resp      (per_resp),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .key       (key),
        .wr_entry  (wr_entry),
        .rd_entry  (rd_entry),
        .wipe      (wipe),
        .wipe_busy (wipe_busy)
    );

    db_store_array db_store_array_inst (
        .clk       (clk),
        .srst      (srst),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .key       (key),
        .wr_entry  (wr_entry),
        .rd_entry  (rd_entry),
        .wipe      (wipe),
        .wipe_busy (wipe_busy)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module db_subsystem_tb \
    -f vlog.f
./obj_dir/Vdb_subsystem_tb

//--- tb/db_subsystem_tb.sv
module db_subsystem_tb import db_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int READY_TIMEOUT  = 1000;
    localparam int ACCEPT_TIMEOUT = 4000;
    localparam int ACK_TIMEOUT    = 1000;
    localparam int RANDOM_CMDS    = 60;

    logic     clk;
    logic     srst;
    logic     hi_req;
    db_cmd_t  hi_cmd;
    logic     hi_rdy;
    logic     hi_ack;
    db_resp_t hi_resp;
    logic     lo_req;
    db_cmd_t  lo_cmd;
    logic     lo_rdy;
    logic     lo_ack;
    db_resp_t lo_resp;

    integer     seed;
    int         cycle;
    db_entry_t  model [DEPTH];
    db_resp_t   exp_hi [$];
    db_resp_t   exp_lo [$];
    db_resp_t   popped;
    int         acc_cycle_hi;
    int         acc_cycle_lo;
    db_opcode_e acc_op_hi;
    db_opcode_e acc_op_lo;

    db_subsystem db_subsystem_inst (
        .clk     (clk),
        .srst    (srst),
        .hi_req  (hi_req),
        .hi_cmd  (hi_cmd),
        .hi_rdy  (hi_rdy),
        .hi_ack  (hi_ack),
        .hi_resp (hi_resp),
        .lo_req  (lo_req),
        .lo_cmd  (lo_cmd),
        .lo_rdy  (lo_rdy),
        .lo_ack  (lo_ack),
        .lo_resp (lo_resp)
    );

    always #5 clk = ~clk;

    // ==================================================
    // Failure reporting and checks
    // ==================================================
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first failure");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %0d ns: %s: got 0x%0h, expected 0x%0h",
                                        $time, what, actual, expected));
        end
    endtask

    // ==================================================
    // Reference model
    // ==================================================
    // Previous flag and value, then the store update
    function automatic db_resp_t expected_resp(input db_cmd_t c);
        db_resp_t  r;
        db_entry_t old;
        r   = '0;
        old = model[c.key];
        if (c.opcode inside {OP_GET, OP_SET, OP_UNSET, OP_REPLACE}) begin
            r.valid = old.valid;
            r.value = old.valid ? old.value : '0;
        end else if (c.opcode != OP_CLEAR_ALL) begin
            r.error = 1'b1;
        end
        if (c.opcode == OP_SET || c.opcode == OP_REPLACE) begin
            model[c.key].valid = 1'b1;
            model[c.key].value = c.value;
        end else if (c.opcode == OP_UNSET) begin
            model[c.key] = '0;
        end else if (c.opcode == OP_CLEAR_ALL) begin
            foreach (model[i]) begin
                model[i] = '0;
            end
        end
        return r;
    endfunction

    // Monitor for both ports
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!srst) begin
            if (hi_req && lo_req && hi_rdy) begin
                check_value(64'(lo_rdy), 64'd0, "port 1 ready while port 0 requests");
            end
            if (hi_req && hi_rdy) begin
                exp_hi.push_back(expected_resp(hi_cmd));
                acc_cycle_hi = cycle;
                acc_op_hi    = hi_cmd.opcode;
            end
            if (lo_req && lo_rdy) begin
                exp_lo.push_back(expected_resp(lo_cmd));
                acc_cycle_lo = cycle;
                acc_op_lo    = lo_cmd.opcode;
            end
            if (hi_ack) begin
                if (exp_hi.size() == 0) begin
                    stop_with_failure("Port 0 acknowledged without an accepted command");
                end else begin
                    popped = exp_hi.pop_front();
                    check_value(64'(hi_resp), 64'(popped), "port 0 response");
                    if (acc_op_hi != OP_CLEAR_ALL) begin
                        check_value(64'(cycle - acc_cycle_hi), 64'd3, "port 0 ack latency");
                    end
                end
            end
            if (lo_ack) begin
                if (exp_lo.size() == 0) begin
                    stop_with_failure("Port 1 acknowledged without an accepted command");
                end else begin
                    popped = exp_lo.pop_front();
                    check_value(64'(lo_resp), 64'(popped), "port 1 response");
                    if (acc_op_lo != OP_CLEAR_ALL) begin
                        check_value(64'(cycle - acc_cycle_lo), 64'd3, "port 1 ack latency");
                    end
                end
            end
        end
    end

    // ==================================================
    // Port drivers
    // ==================================================
    task automatic issue_hi(input db_cmd_t c);
        int n;
        hi_req = 1'b1;
        hi_cmd = c;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ACCEPT_TIMEOUT) begin
                stop_with_failure("Timeout: port 0 command was never accepted");
            end
        end while (!hi_rdy);
        #1;
        hi_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ACK_TIMEOUT) begin
                stop_with_failure("Timeout: port 0 never received its ack");
            end
        end while (!hi_ack);
        #1;
    endtask

    task automatic issue_lo(input db_cmd_t c);
        int n;
        lo_req = 1'b1;
        lo_cmd = c;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ACCEPT_TIMEOUT) begin
                stop_with_failure("Timeout: port 1 command was never accepted");
            end
        end while (!lo_rdy);
        #1;
        lo_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ACK_TIMEOUT) begin
                stop_with_failure("Timeout: port 1 never received its ack");
            end
        end while (!lo_ack);
        #1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > READY_TIMEOUT) begin
                stop_with_failure("Timeout: ports never became ready after reset");
            end
        end while (!(hi_rdy && lo_rdy));
        #1;
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    function automatic db_cmd_t make_cmd(input db_opcode_e op, input db_key_t k,
                                         input db_value_t v);
        db_cmd_t c;
        c.opcode = op;
        c.key    = k;
        c.value  = v;
        return c;
    endfunction

    // Small key range so both ports collide on entries
    function automatic db_cmd_t random_cmd();
        db_cmd_t c;
        int      sel;
        sel     = int'($unsigned($random(seed)) % 20);
        c.key   = db_key_t'($unsigned($random(seed)) % 16);
        c.value = $random(seed);
        if (sel < 5) c.opcode = OP_GET;
        else if (sel < 10) c.opcode = OP_SET;
        else if (sel < 13) c.opcode = OP_UNSET;
        else if (sel < 17) c.opcode = OP_REPLACE;
        else if (sel == 17) c.opcode = OP_CLEAR_ALL;
        else c.opcode = db_opcode_e'(3'(sel - 13));
        return c;
    endfunction

    task automatic random_hi(input int count);
        repeat (count) begin
            issue_hi(random_cmd());
            idle_cycles(1 + int'($unsigned($random(seed)) % 3));
        end
    endtask

    task automatic random_lo(input int count);
        repeat (count) begin
            issue_lo(random_cmd());
            idle_cycles(1 + int'($unsigned($random(seed)) % 3));
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        seed         = 32'h6c997317;
        cycle        = 0;
        acc_cycle_hi = 0;
        acc_cycle_lo = 0;
        acc_op_hi    = OP_GET;
        acc_op_lo    = OP_GET;
        clk          = 1'b0;
        srst         = 1'b1;
        hi_req       = 1'b0;
        hi_cmd       = '0;
        lo_req       = 1'b0;
        lo_cmd       = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        check_value(64'({hi_rdy, hi_ack, lo_rdy, lo_ack}), 64'd0, "port strobes in reset");
        srst = 1'b0;
        wait_ready();

        // Empty store after the reset wipe
        issue_hi(make_cmd(OP_GET, 8'h00, '0));
        issue_lo(make_cmd(OP_GET, 8'hff, '0));
        issue_hi(make_cmd(OP_GET, 8'h5a, '0));

        // Set then get across ports
        issue_hi(make_cmd(OP_SET, 8'h12, 32'hdeadbeef));
        issue_lo(make_cmd(OP_GET, 8'h12, '0));
        issue_lo(make_cmd(OP_SET, 8'h34, 32'h0badcafe));
        issue_hi(make_cmd(OP_GET, 8'h34, '0));

        // Unset and replace
        issue_hi(make_cmd(OP_UNSET, 8'h12, '0));
        issue_lo(make_cmd(OP_GET, 8'h12, '0));
        issue_lo(make_cmd(OP_UNSET, 8'h77, '0));
        issue_lo(make_cmd(OP_REPLACE, 8'h34, 32'h13572468));
        issue_hi(make_cmd(OP_GET, 8'h34, '0));
        issue_hi(make_cmd(OP_REPLACE, 8'h80, 32'h00c0ffee));
        issue_lo(make_cmd(OP_GET, 8'h80, '0));

        // Illegal opcode leaves the entry alone
        issue_lo(make_cmd(db_opcode_e'(3'd7), 8'h34, 32'hffffffff));
        issue_hi(make_cmd(db_opcode_e'(3'd5), 8'h34, 32'h0));
        issue_hi(make_cmd(OP_GET, 8'h34, '0));

        // Clear all from each port
        issue_hi(make_cmd(OP_CLEAR_ALL, 8'h00, '0));
        issue_lo(make_cmd(OP_GET, 8'h34, '0));
        issue_lo(make_cmd(OP_GET, 8'h80, '0));
        issue_hi(make_cmd(OP_SET, 8'h01, 32'h11111111));
        issue_hi(make_cmd(OP_SET, 8'hfe, 32'h22222222));
        issue_lo(make_cmd(OP_CLEAR_ALL, 8'h00, '0));
        issue_hi(make_cmd(OP_GET, 8'h01, '0));
        issue_lo(make_cmd(OP_GET, 8'hfe, '0));

        // Both ports at once
        fork
            random_hi(RANDOM_CMDS);
            random_lo(RANDOM_CMDS);
        join
        idle_cycles(2);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- vlog.f
common/db_pkg.sv
db_mux/db_ctrl_prio_mux.sv
db_engine/db_store_array.sv
db_engine/db_peripheral.sv
logic/db_subsystem.sv
tb/db_subsystem_tb.sv
